// ==== common/banked_mem_defines.svh ====
////////////////////////////////////////
// Banked scratchpad constants
// Widths, bank geometry and address offsets
////////////////////////////////////////
`ifndef BANKED_MEM_DEFINES_SVH
`define BANKED_MEM_DEFINES_SVH

// Byte address width, shared by the wide and narrow ports
`define BM_ADDR_W 16
// Wide port and bank data widths
`define BM_MEM_DATA_W 128
`define BM_BANK_DATA_W 32
// Addressable unit, one byte
`define BM_WORD_SIZE 8
`define BM_NUM_BANKS 4
// log2 of the wide word in bytes
`define BM_BANK_ADDR_OFFSET 4
`define BM_BANK_DEPTH 64
// Derived strobe and index widths
`define BM_MEM_STRB_W (`BM_MEM_DATA_W / `BM_WORD_SIZE)
`define BM_BANK_STRB_W (`BM_BANK_DATA_W / `BM_WORD_SIZE)
`define BM_ROW_W 6
// Narrow bank select sits at byte address bits 3:2
`define BM_BANK_SEL_LSB 2
`define BM_BANK_SEL_W 2

`endif

// ==== common/banked_mem_pkg.sv ====
////////////////////////////////////////
// Banked scratchpad types
// Wide and bank request/response structs
////////////////////////////////////////
`default_nettype none

package banked_mem_pkg;

`include "banked_mem_defines.svh"

    // Wide request payload
    typedef struct packed {
        logic [`BM_ADDR_W-1:0]     addr;
        logic [`BM_MEM_DATA_W-1:0] data;
        logic [`BM_MEM_STRB_W-1:0] strb;
        logic                      write;
    } mem_q_t;

    typedef struct packed {
        logic   q_valid;
        mem_q_t q;
    } mem_req_t;

    // Wide response, no ready on this side
    typedef struct packed {
        logic [`BM_MEM_DATA_W-1:0] data;
        logic                      valid;
    } mem_p_t;

    typedef struct packed {
        logic   q_ready;
        mem_p_t p;
    } mem_rsp_t;

    // Bank side, also used by the narrow port
    typedef struct packed {
        logic [`BM_ADDR_W-1:0]      addr;
        logic [`BM_BANK_DATA_W-1:0] data;
        logic [`BM_BANK_STRB_W-1:0] strb;
        logic                       write;
    } bank_q_t;

    typedef struct packed {
        logic    q_valid;
        bank_q_t q;
    } bank_req_t;

    typedef struct packed {
        logic [`BM_BANK_DATA_W-1:0] data;
        logic                       valid;
    } bank_p_t;

    typedef struct packed {
        logic    q_ready;
        bank_p_t p;
    } bank_rsp_t;

    // Owner of a bank access, one per bank arbiter
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_WIDE,
        GRANT_NARROW
    } grant_e;

endpackage

`default_nettype wire

// ==== rtl/wide_to_narrow_splitter.sv ====
////////////////////////////////////////
// Wide to narrow splitter
// One wide request into four bank lanes
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "banked_mem_defines.svh"

module wide_to_narrow_splitter
    import banked_mem_pkg::*;
(
    // Split and merge are combinational; clock and reset are unused
    input  logic                            clk_i,
    input  logic                            rst_i,

    // Wide side
    input  mem_req_t                        mem_req_i,
    output mem_rsp_t                        mem_rsp_o,

    // One lane per bank
    output bank_req_t [`BM_NUM_BANKS-1:0]   bank_req_o,
    input  bank_rsp_t [`BM_NUM_BANKS-1:0]   bank_rsp_i
);

    localparam int unsigned NumBanks   = `BM_NUM_BANKS;
    localparam int unsigned LaneW      = `BM_BANK_DATA_W;
    localparam int unsigned LaneStrbW  = `BM_BANK_STRB_W;
    // Byte stride between consecutive bank addresses
    localparam int unsigned LaneStride = 1 << `BM_BANK_ADDR_OFFSET;

    logic [NumBanks-1:0] lane_ready;
    logic [NumBanks-1:0] lane_valid;
    logic                all_ready;

    // Gather per-bank handshake bits
    for (genvar i = 0; i < NumBanks; i++) begin : gen_collect
        assign lane_ready[i] = bank_rsp_i[i].q_ready;
        assign lane_valid[i] = bank_rsp_i[i].p.valid;
    end

    // A wide request goes out only when every bank can take its lane
    assign all_ready = &lane_ready;

    for (genvar i = 0; i < NumBanks; i++) begin : gen_split_req
        // Valid gated so a wide access is never taken in part
        assign bank_req_o[i].q_valid = mem_req_i.q_valid & all_ready;
        // Lane i sits i wide words above the base address
        assign bank_req_o[i].q.addr  = mem_req_i.q.addr
                                     + `BM_ADDR_W'(i * LaneStride);
        assign bank_req_o[i].q.data  = mem_req_i.q.data[i*LaneW +: LaneW];
        assign bank_req_o[i].q.strb  = mem_req_i.q.strb[i*LaneStrbW +: LaneStrbW];
        assign bank_req_o[i].q.write = mem_req_i.q.write;
    end

    // Merge lane read data back into the wide word
    for (genvar i = 0; i < NumBanks; i++) begin : gen_merge_rsp
        assign mem_rsp_o.p.data[i*LaneW +: LaneW] = bank_rsp_i[i].p.data;
    end

    // Lanes respond in lockstep, so AND is enough
    assign mem_rsp_o.p.valid = &lane_valid;
    assign mem_rsp_o.q_ready = all_ready;

endmodule

`default_nettype wire

// ==== rtl/bank_arbiter.sv ====
////////////////////////////////////////
// Bank arbiter
// Narrow-first grant with a wide catch-up turn
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "banked_mem_defines.svh"

module bank_arbiter
    import banked_mem_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Wide lane from the splitter
    input  bank_req_t                   wide_req_i,
    output bank_rsp_t                   wide_rsp_o,

    // Narrow port, already decoded to this bank
    input  bank_req_t                   narrow_req_i,
    output bank_rsp_t                   narrow_rsp_o,

    // Bank access
    output bank_q_t                     sram_req_o,
    output logic                        sram_en_o,
    input  logic [`BM_BANK_DATA_W-1:0]  sram_rdata_i
);

    logic   wide_prio_q;
    logic   wide_ready;
    logic   narrow_ready;
    logic   wide_grant;
    logic   narrow_grant;
    grant_e owner_q;

    // Wide lane wins when narrow is idle or when it was held off last cycle
    assign wide_ready   = ~narrow_req_i.q_valid | wide_prio_q;
    // Narrow yields for one cycle after taking the bank
    assign narrow_ready = ~wide_prio_q;

    // At most one of these is high
    assign wide_grant   = wide_req_i.q_valid & wide_ready;
    assign narrow_grant = narrow_req_i.q_valid & narrow_ready;

    assign sram_en_o  = wide_grant | narrow_grant;
    assign sram_req_o = wide_grant ? wide_req_i.q : narrow_req_i.q;

    // Owner and catch-up flag
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            owner_q     <= GRANT_NONE;
            wide_prio_q <= 1'b0;
        end else begin
            if (wide_grant) begin
                owner_q <= GRANT_WIDE;
            end else if (narrow_grant) begin
                owner_q <= GRANT_NARROW;
            end else begin
                owner_q <= GRANT_NONE;
            end
            // Narrow took the bank, so the wide lane gets the next turn
            wide_prio_q <= narrow_grant;
        end
    end

    // Response goes back only to the side that owned the access
    always_comb begin
        wide_rsp_o.q_ready   = wide_ready;
        wide_rsp_o.p.valid   = (owner_q == GRANT_WIDE);
        wide_rsp_o.p.data    = (owner_q == GRANT_WIDE) ? sram_rdata_i : '0;
        narrow_rsp_o.q_ready = narrow_ready;
        narrow_rsp_o.p.valid = (owner_q == GRANT_NARROW);
        narrow_rsp_o.p.data  = (owner_q == GRANT_NARROW) ? sram_rdata_i : '0;
    end

endmodule

`default_nettype wire

// ==== rtl/sram_bank.sv ====
////////////////////////////////////////
// SRAM bank
// 32-bit byte-strobed, one cycle read latency
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "banked_mem_defines.svh"

module sram_bank
    import banked_mem_pkg::*;
(
    input  logic                        clk_i,
    // Access strobe from the arbiter
    input  logic                        en_i,
    input  bank_q_t                     req_i,
    output logic [`BM_BANK_DATA_W-1:0]  rdata_o
);

    localparam int unsigned DataW = `BM_BANK_DATA_W;
    localparam int unsigned StrbW = `BM_BANK_STRB_W;
    localparam int unsigned ByteW = `BM_WORD_SIZE;
    localparam int unsigned Depth = `BM_BANK_DEPTH;
    localparam int unsigned RowW  = `BM_ROW_W;

    logic [DataW-1:0] mem_q [Depth];
    logic [DataW-1:0] rdata_q;
    logic [RowW-1:0]  row;

    // Row is the wide-word index, wrapped to the bank depth
    assign row = req_i.addr[`BM_BANK_ADDR_OFFSET +: RowW];

    // Byte-masked write at the accepting edge
    always_ff @(posedge clk_i) begin
        if (en_i && req_i.write) begin
            for (int b = 0; b < StrbW; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[row][b*ByteW +: ByteW] <= req_i.data[b*ByteW +: ByteW];
                end
            end
        end
    end

    // Read data registered on every access
    // Value on a write is old contents, which callers ignore
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_q <= mem_q[row];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/banked_mem_top.sv ====
////////////////////////////////////////
// Banked scratchpad top
// Wide and narrow ports over four banks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "banked_mem_defines.svh"

module banked_mem_top
    import banked_mem_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // 128-bit port
    input  mem_req_t   wide_req_i,
    output mem_rsp_t   wide_rsp_o,

    // 32-bit port
    input  bank_req_t  narrow_req_i,
    output bank_rsp_t  narrow_rsp_o
);

    localparam int unsigned NumBanks = `BM_NUM_BANKS;
    localparam int unsigned SelW     = `BM_BANK_SEL_W;

    bank_req_t [NumBanks-1:0]                      lane_req;
    bank_rsp_t [NumBanks-1:0]                      lane_rsp;
    bank_req_t [NumBanks-1:0]                      nar_req;
    bank_rsp_t [NumBanks-1:0]                      nar_rsp;
    bank_q_t   [NumBanks-1:0]                      sram_req;
    logic      [NumBanks-1:0]                      sram_en;
    logic      [NumBanks-1:0][`BM_BANK_DATA_W-1:0] sram_rdata;

    logic [SelW-1:0] nar_sel;
    logic [SelW-1:0] nar_sel_q;

    // Wide request split into per-bank lanes
    wide_to_narrow_splitter u_splitter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mem_req_i  (wide_req_i),
        .mem_rsp_o  (wide_rsp_o),
        .bank_req_o (lane_req),
        .bank_rsp_i (lane_rsp)
    );

    // Narrow bank select from the word bits of the byte address
    assign nar_sel = narrow_req_i.q.addr[`BM_BANK_SEL_LSB +: SelW];

    // Remember which bank serves the narrow response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            nar_sel_q <= '0;
        end else if (narrow_req_i.q_valid && narrow_rsp_o.q_ready) begin
            nar_sel_q <= nar_sel;
        end
    end

    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
        // Steer the narrow valid to the selected bank only
        assign nar_req[b].q_valid = narrow_req_i.q_valid && (nar_sel == SelW'(b));
        assign nar_req[b].q       = narrow_req_i.q;

        bank_arbiter u_arb (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .wide_req_i   (lane_req[b]),
            .wide_rsp_o   (lane_rsp[b]),
            .narrow_req_i (nar_req[b]),
            .narrow_rsp_o (nar_rsp[b]),
            .sram_req_o   (sram_req[b]),
            .sram_en_o    (sram_en[b]),
            .sram_rdata_i (sram_rdata[b])
        );

        sram_bank u_sram (
            .clk_i   (clk_i),
            .en_i    (sram_en[b]),
            .req_i   (sram_req[b]),
            .rdata_o (sram_rdata[b])
        );
    end

    // Ready follows the addressed bank, response the bank that accepted
    assign narrow_rsp_o.q_ready = nar_rsp[nar_sel].q_ready;
    assign narrow_rsp_o.p       = nar_rsp[nar_sel_q].p;

endmodule

`default_nettype wire

// ==== dv/banked_mem_properties.sv ====
////////////////////////////////////////
// Banked scratchpad handshake checks
// Response timing and reset behavior
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module banked_mem_properties
    import banked_mem_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input mem_req_t  wide_req_i,
    input mem_rsp_t  wide_rsp_i,
    input bank_req_t narrow_req_i,
    input bank_rsp_t narrow_rsp_i
);

    logic        wide_acc;
    logic        narrow_acc;
    // Read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    assign wide_acc   = wide_req_i.q_valid && wide_rsp_i.q_ready;
    assign narrow_acc = narrow_req_i.q_valid && narrow_rsp_i.q_ready;

    // Accepted request answered on the very next edge
    wide_rsp_next: assert property (@(posedge clk_i) disable iff (rst_i)
        wide_acc |=> wide_rsp_i.p.valid)
        else begin
            fail_count++;
            $error("wide response missing one cycle after acceptance");
        end

    narrow_rsp_next: assert property (@(posedge clk_i) disable iff (rst_i)
        narrow_acc |=> narrow_rsp_i.p.valid)
        else begin
            fail_count++;
            $error("narrow response missing one cycle after acceptance");
        end

    // No response without an acceptance one cycle before
    wide_rsp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        wide_rsp_i.p.valid |-> $past(wide_acc))
        else begin
            fail_count++;
            $error("wide response without an accepted request");
        end

    narrow_rsp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        narrow_rsp_i.p.valid |-> $past(narrow_acc))
        else begin
            fail_count++;
            $error("narrow response without an accepted request");
        end

    // Both responses quiet on the first edge out of reset
    rsp_low_after_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !wide_rsp_i.p.valid && !narrow_rsp_i.p.valid)
        else begin
            fail_count++;
            $error("response valid high right after reset");
        end

endmodule

bind banked_mem_top banked_mem_properties u_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wide_req_i   (wide_req_i),
    .wide_rsp_i   (wide_rsp_o),
    .narrow_req_i (narrow_req_i),
    .narrow_rsp_i (narrow_rsp_o)
);

`default_nettype wire

// ==== dv/banked_mem_tb.sv ====
////////////////////////////////////////
// Banked scratchpad testbench
// Wide and narrow traffic against a byte model
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "banked_mem_defines.svh"

module banked_mem_tb
    import banked_mem_pkg::*;
();

    localparam int WaitLimit = 50;

    logic      clk;
    logic      rst;
    mem_req_t  wide_req;
    mem_rsp_t  wide_rsp;
    bank_req_t narrow_req;
    bank_rsp_t narrow_rsp;

    int seed = 37;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    // Byte model indexed by {bank, row, byte}
    logic [7:0] model [1024];

    banked_mem_top uut (
        .clk_i        (clk),
        .rst_i        (rst),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Bank from address bits 3:2, row from bits 9:4
    function automatic logic [9:0] byte_idx(logic [`BM_ADDR_W-1:0] a, int j);
        return {a[3:2], a[9:4], 2'(j)};
    endfunction

    // Narrow address that reaches lane i of a wide access at a
    function automatic logic [`BM_ADDR_W-1:0] lane_addr(logic [`BM_ADDR_W-1:0] a, int i);
        logic [`BM_ADDR_W-1:0] s;
        s = a + `BM_ADDR_W'(16 * i);
        return {s[`BM_ADDR_W-1:4], 2'(i), 2'b00};
    endfunction

    task automatic model_write(logic [`BM_ADDR_W-1:0] a, logic [31:0] d, logic [3:0] s);
        for (int j = 0; j < 4; j++) begin
            if (s[j]) begin
                model[byte_idx(a, j)] = d[8*j +: 8];
            end
        end
    endtask

    function automatic logic [31:0] model_read(logic [`BM_ADDR_W-1:0] a);
        logic [31:0] d;
        for (int j = 0; j < 4; j++) begin
            d[8*j +: 8] = model[byte_idx(a, j)];
        end
        return d;
    endfunction

    // Aligned wide address for row k, random upper bits
    function automatic logic [`BM_ADDR_W-1:0] wide_addr(int k);
        return {6'($random(seed)), 6'(k), 4'b0000};
    endfunction

    function automatic logic [127:0] rand_wide();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic wide_access(logic wr, logic [`BM_ADDR_W-1:0] a, logic [127:0] d,
                               logic [15:0] s);
        int waited;
        logic acc;
        logic [127:0] exp;
        @(posedge clk);
        wide_req.q_valid <= 1'b1;
        wide_req.q       <= '{addr: a, data: d, strb: s, write: wr};
        @(negedge clk);
        for (waited = 0; !wide_rsp.q_ready && waited < WaitLimit; waited++)
            @(negedge clk);
        // Ready is stable until the next edge, so this decides acceptance
        acc = wide_rsp.q_ready;
        @(posedge clk);
        wide_req.q_valid <= 1'b0;
        if (!acc) begin
            timeouts++;
            $display("Timeout at %0t: wide request to %h never accepted", $time, a);
            return;
        end
        // Accepted at this edge, so the model moves now
        for (int i = 0; i < 4; i++) begin
            if (wr) begin
                model_write(lane_addr(a, i), d[32*i +: 32], s[4*i +: 4]);
            end
            exp[32*i +: 32] = model_read(lane_addr(a, i));
        end
        @(negedge clk);
        for (waited = 0; !wide_rsp.p.valid && waited < WaitLimit; waited++)
            @(negedge clk);
        if (!wide_rsp.p.valid) begin
            timeouts++;
            $display("Timeout at %0t: no wide response for %h", $time, a);
            return;
        end
        checks++;
        if (!wr) begin
            assert (wide_rsp.p.data === exp) else begin
                errors++;
                $display("[ERROR] %0t wide_rsp.p.data expected %h got %h",
                         $time, exp, wide_rsp.p.data);
            end
        end
    endtask

    task automatic narrow_access(logic wr, logic [`BM_ADDR_W-1:0] a, logic [31:0] d,
                                 logic [3:0] s);
        int waited;
        logic acc;
        logic [31:0] exp;
        @(posedge clk);
        narrow_req.q_valid <= 1'b1;
        narrow_req.q       <= '{addr: a, data: d, strb: s, write: wr};
        @(negedge clk);
        for (waited = 0; !narrow_rsp.q_ready && waited < WaitLimit; waited++)
            @(negedge clk);
        acc = narrow_rsp.q_ready;
        @(posedge clk);
        narrow_req.q_valid <= 1'b0;
        if (!acc) begin
            timeouts++;
            $display("Timeout at %0t: narrow request to %h never accepted", $time, a);
            return;
        end
        if (wr) begin
            model_write(a, d, s);
        end
        exp = model_read(a);
        @(negedge clk);
        for (waited = 0; !narrow_rsp.p.valid && waited < WaitLimit; waited++)
            @(negedge clk);
        if (!narrow_rsp.p.valid) begin
            timeouts++;
            $display("Timeout at %0t: no narrow response for %h", $time, a);
            return;
        end
        checks++;
        if (!wr) begin
            assert (narrow_rsp.p.data === exp) else begin
                errors++;
                $display("[ERROR] %0t narrow_rsp.p.data expected %h got %h",
                         $time, exp, narrow_rsp.p.data);
            end
        end
    endtask

    task automatic read_all_wide();
        for (int k = 0; k < 64; k++) begin
            wide_access(1'b0, wide_addr(k), '0, '0);
        end
    endtask

    initial begin
        wide_req   = '0;
        narrow_req = '0;
        rst        = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Idle after reset, no responses expected
        repeat (8) begin
            @(negedge clk);
            checks += 2;
            assert (!wide_rsp.p.valid) else begin
                errors++;
                $display("[ERROR] %0t wide_rsp.p.valid expected 0 got %b",
                         $time, wide_rsp.p.valid);
            end
            assert (!narrow_rsp.p.valid) else begin
                errors++;
                $display("[ERROR] %0t narrow_rsp.p.valid expected 0 got %b",
                         $time, narrow_rsp.p.valid);
            end
        end
        // Full-strobe fill of every row, then read back
        for (int k = 0; k < 64; k++) begin
            wide_access(1'b1, wide_addr(k), rand_wide(), '1);
        end
        read_all_wide();
        // Partial strobes touch only enabled bytes
        repeat (32) wide_access(1'b1, wide_addr($random(seed)), rand_wide(), 16'($random(seed)));
        read_all_wide();
        // Narrow side of the lane mapping, seen from both ports
        repeat (48) narrow_access(1'($random(seed)), {14'($random(seed)), 2'b00},
                                  32'($random(seed)), 4'($random(seed)));
        read_all_wide();
        // Both ports contending for the same banks
        fork
            repeat (40) wide_access(1'($random(seed)), wide_addr($random(seed)),
                                    rand_wide(), 16'($random(seed)));
            repeat (80) narrow_access(1'($random(seed)), {14'($random(seed)), 2'b00},
                                      32'($random(seed)), 4'($random(seed)));
        join
        read_all_wide();
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, uut.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && uut.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/banked_mem_pkg.sv
rtl/wide_to_narrow_splitter.sv
rtl/bank_arbiter.sv
rtl/sram_bank.sv
rtl/banked_mem_top.sv
dv/banked_mem_properties.sv
dv/banked_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the banked scratchpad

VERILATOR  ?= verilator
TOP        ?= banked_mem_tb
DUT_TOP    ?= banked_mem_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= *** TEST PASSED ***
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
